// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_decode
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= === PASS ===

SOURCES := $(filter %.sv %.v,$(shell cat $(FLIST)))
HEADERS := rv_decode_config.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// ==== decode_patterns.hex ====
// word fu_type alu_func opa_select opb_select flags rs_used
// flags: has_dest rd_mem wr_mem cond uncond mult csr halt illegal (msb first)
003100b3 0 0 0 0 100 3
40628233 0 1 0 0 100 3
009413b3 0 7 0 0 100 3
00c5a533 0 2 0 0 100 3
00f736b3 0 3 0 0 100 3
0128c833 0 6 0 0 100 3
015a59b3 0 8 0 0 100 3
418bdb33 0 9 0 0 100 3
01bd6cb3 0 5 0 0 100 3
01eefe33 0 4 0 0 100 3
00500093 0 0 0 1 100 2
fff0a113 0 2 0 1 100 2
0010b193 0 3 0 1 100 2
0ff0c213 0 6 0 1 100 2
0100e293 0 5 0 1 100 2
0070f313 0 4 0 1 100 2
00309393 0 7 0 1 100 2
4020d413 0 9 0 1 100 2
12345537 0 0 2 4 100 0
00001597 0 0 1 4 100 0
00208033 0 0 0 0 000 3
00812603 1 0 0 1 180 2
00d12623 1 0 0 2 040 3
00208863 3 0 1 3 020 3
008000ef 3 0 1 5 110 0
00008067 3 0 0 1 010 2
03078733 2 0 0 0 108 3
033938b3 2 0 0 0 108 3
ffffffff 0 0 0 0 001 3
10500073 0 0 0 0 002 3

// ==== decode_queue.sv ====
// ******************************
// decode queue
// circular FIFO of decode packets toward dispatch
// ******************************

`timescale 1ns/1ps
`include "rv_decode_config.svh"

module decode_queue (
    input  logic                          clock,
    input  logic                          rst_n,
    fetch_decode_if.sink                  fd,
    input  rv_decode_pkg::decode_packet_t in_packet,
    output logic                          out_valid,
    input  logic                          out_ready,
    output rv_decode_pkg::decode_packet_t out_packet
);

    localparam int ptr_w = $clog2(`RV_QUEUE_DEPTH);
    localparam logic [ptr_w:0] queue_depth = `RV_QUEUE_DEPTH;

    rv_decode_pkg::decode_packet_t entries [`RV_QUEUE_DEPTH];

    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [ptr_w:0]   count_q;
    logic             full;
    logic             push;
    logic             pop;

    assign full = (count_q == queue_depth);

    // a full queue still takes a word when the head leaves in the same cycle
    assign fd.ready = !full || out_ready;

    assign push = fd.valid && fd.ready;
    assign pop  = out_valid && out_ready;

    assign out_valid  = (count_q != '0);
    assign out_packet = entries[rd_ptr_q];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            entries[wr_ptr_q] <= in_packet;
        end
    end

endmodule

// ==== decoder.sv ====
// ******************************
// RV32IM decoder
// combinational word to control packet
// ******************************

`timescale 1ns/1ps
`include "rv_decode_config.svh"

module decoder (
    fetch_decode_if.sink                  fd,
    output rv_decode_pkg::decode_packet_t packet,
    output logic                          halt
);

    localparam logic [6:0]  op_lui    = 7'b0110111;
    localparam logic [6:0]  op_auipc  = 7'b0010111;
    localparam logic [6:0]  op_jal    = 7'b1101111;
    localparam logic [6:0]  op_jalr   = 7'b1100111;
    localparam logic [6:0]  op_branch = 7'b1100011;
    localparam logic [6:0]  op_load   = 7'b0000011;
    localparam logic [6:0]  op_store  = 7'b0100011;
    localparam logic [6:0]  op_imm    = 7'b0010011;
    localparam logic [6:0]  op_reg    = 7'b0110011;
    localparam logic [6:0]  op_system = 7'b1110011;
    localparam logic [31:0] wfi_word  = 32'h1050_0073;

    // funct7, funct3 and opcode side by side for matching
    logic [16:0] key;

    // alt picks sub or sra, the caller masks it where it has no meaning
    function automatic rv_decode_pkg::alu_func_t alu_from_funct(
        input logic [2:0] funct3,
        input logic       alt
    );
        case (funct3)
            3'b000: begin
                if (alt) return rv_decode_pkg::alu_sub;
                return rv_decode_pkg::alu_add;
            end
            3'b001: return rv_decode_pkg::alu_sll;
            3'b010: return rv_decode_pkg::alu_slt;
            3'b011: return rv_decode_pkg::alu_sltu;
            3'b100: return rv_decode_pkg::alu_xor;
            3'b101: begin
                if (alt) return rv_decode_pkg::alu_sra;
                return rv_decode_pkg::alu_srl;
            end
            3'b110: return rv_decode_pkg::alu_or;
            default: return rv_decode_pkg::alu_and;
        endcase
    endfunction

    assign key = {fd.inst.r.funct7, fd.inst.r.funct3, fd.inst.r.opcode};

    always_comb begin
        packet.inst   = fd.inst;
        packet.pc     = fd.pc;
        packet.npc    = fd.pc + 32'd4;
        packet.funct3 = fd.inst.r.funct3;

        // defaults look like a nop
        packet.opa_select    = rv_decode_pkg::opa_is_rs1;
        packet.opb_select    = rv_decode_pkg::opb_is_rs2;
        packet.alu_func      = rv_decode_pkg::alu_add;
        packet.has_dest      = `FALSE;
        packet.rd_mem        = `FALSE;
        packet.wr_mem        = `FALSE;
        packet.cond_branch   = `FALSE;
        packet.uncond_branch = `FALSE;
        packet.mult          = `FALSE;
        packet.csr_op        = `FALSE;
        packet.halt          = `FALSE;
        packet.illegal       = `FALSE;

        if (fd.inst == wfi_word) begin
            packet.halt = `TRUE;
        end else begin
            casez (key)
                {7'b???????, 3'b???, op_lui}: begin
                    packet.has_dest   = `TRUE;
                    packet.opa_select = rv_decode_pkg::opa_is_zero;
                    packet.opb_select = rv_decode_pkg::opb_is_u_imm;
                end
                {7'b???????, 3'b???, op_auipc}: begin
                    packet.has_dest   = `TRUE;
                    packet.opa_select = rv_decode_pkg::opa_is_pc;
                    packet.opb_select = rv_decode_pkg::opb_is_u_imm;
                end
                {7'b???????, 3'b???, op_jal}: begin
                    packet.has_dest      = `TRUE;
                    packet.opa_select    = rv_decode_pkg::opa_is_pc;
                    packet.opb_select    = rv_decode_pkg::opb_is_j_imm;
                    packet.uncond_branch = `TRUE;
                end
                {7'b???????, 3'b000, op_jalr}: begin
                    packet.has_dest      = `TRUE;
                    packet.opb_select    = rv_decode_pkg::opb_is_i_imm;
                    packet.uncond_branch = `TRUE;
                end
                // beq bne blt bge bltu bgeu, funct3 is the compare
                {7'b???????, 3'b00?, op_branch},
                {7'b???????, 3'b1??, op_branch}: begin
                    packet.opa_select  = rv_decode_pkg::opa_is_pc;
                    packet.opb_select  = rv_decode_pkg::opb_is_b_imm;
                    packet.cond_branch = `TRUE;
                end
                {7'b???????, 3'b00?, op_load},
                {7'b???????, 3'b010, op_load},
                {7'b???????, 3'b10?, op_load}: begin
                    packet.has_dest   = `TRUE;
                    packet.opb_select = rv_decode_pkg::opb_is_i_imm;
                    packet.rd_mem     = `TRUE;
                end
                {7'b???????, 3'b00?, op_store},
                {7'b???????, 3'b010, op_store}: begin
                    packet.opb_select = rv_decode_pkg::opb_is_s_imm;
                    packet.wr_mem     = `TRUE;
                end
                // addi slti sltiu xori ori andi, then the three shifts
                {7'b???????, 3'b000, op_imm},
                {7'b???????, 3'b01?, op_imm},
                {7'b???????, 3'b1?0, op_imm},
                {7'b???????, 3'b111, op_imm},
                {7'b0000000, 3'b001, op_imm},
                {7'b0?00000, 3'b101, op_imm}: begin
                    packet.has_dest   = `TRUE;
                    packet.opb_select = rv_decode_pkg::opb_is_i_imm;
                    packet.alu_func   = alu_from_funct(fd.inst.r.funct3,
                        fd.inst.r.funct3 == 3'b101 && fd.inst.r.funct7[5]);
                end
                {7'b0000000, 3'b???, op_reg},
                {7'b0100000, 3'b000, op_reg},
                {7'b0100000, 3'b101, op_reg}: begin
                    packet.has_dest = `TRUE;
                    packet.alu_func = alu_from_funct(fd.inst.r.funct3, fd.inst.r.funct7[5]);
                end
                // mul mulh mulhsu mulhu, funct3 goes on as the mult function
                {7'b0000001, 3'b0??, op_reg}: begin
                    packet.has_dest = `TRUE;
                    packet.mult     = `TRUE;
                end
                {7'b???????, 3'b001, op_system},
                {7'b???????, 3'b01?, op_system}: begin
                    packet.csr_op = `TRUE;
                end
                default: begin
                    packet.illegal = `TRUE;
                end
            endcase
        end

        // writes to x0 are dropped
        if (fd.inst.r.rd == 5'd0) begin
            packet.has_dest = `FALSE;
        end

        packet.is_rs1_used = packet.cond_branch ||
                             (packet.opa_select == rv_decode_pkg::opa_is_rs1);
        packet.is_rs2_used = packet.cond_branch || packet.wr_mem ||
                             (packet.opb_select == rv_decode_pkg::opb_is_rs2);

        // branch unit wins over memory, memory over multiply
        if (packet.cond_branch || packet.uncond_branch) begin
            packet.fu_type = rv_decode_pkg::bu;
        end else if (packet.rd_mem || packet.wr_mem) begin
            packet.fu_type = rv_decode_pkg::ldst;
        end else if (packet.mult) begin
            packet.fu_type = rv_decode_pkg::mult;
        end else begin
            packet.fu_type = rv_decode_pkg::alu;
        end
    end

    assign halt = packet.halt;

endmodule

// ==== fetch_decode_if.sv ====
// ******************************
// fetch to decode handoff
// one word with its pc, valid/ready
// ******************************

`timescale 1ns/1ps

interface fetch_decode_if;

    logic                 valid;
    logic                 ready;
    logic [31:0]          pc;
    rv_decode_pkg::inst_t inst;

    // fetch unit side
    modport fetch (output valid, output pc, output inst, input ready);

    // decoder reads only, queue drives ready
    modport sink (input valid, input pc, input inst, output ready);

endinterface

// ==== fetch_unit.sv ====
// ******************************
// fetch unit
// sequential AXI4-Lite instruction reads into a one-word holding register
// ******************************

`timescale 1ns/1ps
`include "rv_decode_config.svh"

module fetch_unit (
    input  logic          clock,
    input  logic          rst_n,
    output logic          arvalid,
    output logic [31:0]   araddr,
    output logic [2:0]    arprot,
    input  logic          arready,
    input  logic          rvalid,
    input  logic [31:0]   rdata,
    input  logic [1:0]    rresp,
    output logic          rready,
    input  logic          halt_in,
    fetch_decode_if.fetch fd,
    output logic          halted
);

    logic [31:0] pc_q;
    logic        arvalid_q;
    logic        outstanding_q;
    logic        hold_valid_q;
    logic [31:0] hold_word_q;
    logic [31:0] hold_pc_q;
    logic        halted_q;
    logic        ar_fire;
    logic        r_fire;
    logic        fd_fire;
    logic        issue;

    assign ar_fire = arvalid_q && arready;
    assign r_fire  = rvalid && rready;
    assign fd_fire = hold_valid_q && fd.ready;

    // next request goes out as the held word is handed over,
    // never once a halt word has been accepted
    assign issue = !arvalid_q && !outstanding_q && (!hold_valid_q || fd_fire)
                   && !halted_q && !(fd_fire && halt_in);

    assign arvalid = arvalid_q;
    assign araddr  = pc_q;
    // instruction access, unprivileged, secure
    assign arprot  = 3'b100;
    // rresp is ignored, an error response is taken like okay
    assign rready  = outstanding_q && !hold_valid_q;
    assign halted  = halted_q;

    assign fd.valid = hold_valid_q;
    assign fd.pc    = hold_pc_q;
    assign fd.inst  = hold_word_q;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc_q          <= `RV_RESET_PC;
            arvalid_q     <= 1'b0;
            outstanding_q <= 1'b0;
            hold_valid_q  <= 1'b0;
            halted_q      <= 1'b0;
        end else begin
            if (ar_fire) begin
                arvalid_q <= 1'b0;
            end else if (issue) begin
                arvalid_q <= 1'b1;
            end

            if (ar_fire) begin
                outstanding_q <= 1'b1;
            end else if (r_fire) begin
                outstanding_q <= 1'b0;
            end

            // step to the next word once this one is back
            if (r_fire) begin
                hold_valid_q <= 1'b1;
                pc_q         <= pc_q + 32'd4;
            end else if (fd_fire) begin
                hold_valid_q <= 1'b0;
            end

            if (fd_fire && halt_in) begin
                halted_q <= 1'b1;
            end
        end
    end

    // held word and the address it came from
    always_ff @(posedge clock) begin
        if (r_fire) begin
            hold_word_q <= rdata;
            hold_pc_q   <= pc_q;
        end
    end

endmodule

// ==== flist.f ====
+incdir+.
rv_decode_pkg.sv
fetch_decode_if.sv
fetch_unit.sv
decoder.sv
decode_queue.sv
rv_decode_top.sv
rv_decode_assertions.sv
rv_decode_checker.sv
tb_rv_decode.sv

// ==== rv_decode_assertions.sv ====
// ******************************
// handshake assertions for the decode front end
// ******************************

`timescale 1ns/1ps

module rv_decode_assertions (
    input logic                          clock,
    input logic                          rst_n,
    input logic                          arvalid,
    input logic [31:0]                   araddr,
    input logic [2:0]                    arprot,
    input logic                          arready,
    input logic                          rvalid,
    input logic                          rready,
    input logic                          out_valid,
    input logic                          out_ready,
    input rv_decode_pkg::decode_packet_t out_packet,
    input logic                          halted
);

    int   failures = 0;
    logic outstanding;

    // one read in flight between the address and data handshakes
    always @(posedge clock) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (arvalid && arready) begin
            outstanding <= 1'b1;
        end else if (rvalid && rready) begin
            outstanding <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clock) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
    else begin
        $error("arvalid dropped or araddr changed before the address handshake");
        failures++;
    end

    ar_prot: assert property (@(posedge clock) disable iff (!rst_n)
        arvalid |-> arprot == 3'b100)
    else begin
        $error("arprot is not an unprivileged secure instruction access");
        failures++;
    end

    out_hold: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_packet))
    else begin
        $error("out_valid dropped or out_packet changed before dispatch");
        failures++;
    end

    single_read: assert property (@(posedge clock) disable iff (!rst_n)
        outstanding |-> !arvalid)
    else begin
        $error("second read address issued while a read is outstanding");
        failures++;
    end

    no_fetch_halted: assert property (@(posedge clock) disable iff (!rst_n)
        halted |-> !arvalid)
    else begin
        $error("arvalid high while the fetch unit is halted");
        failures++;
    end

endmodule

// ==== rv_decode_checker.sv ====
// ******************************
// dispatch checker
// compares each dispatched packet with its pattern line
// ******************************

`timescale 1ns/1ps

module rv_decode_checker #(
    parameter int num_patterns = 1
) (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          out_valid,
    input  logic                          out_ready,
    input  rv_decode_pkg::decode_packet_t out_packet,
    input  logic                          halted,
    input  logic [31:0]                   patterns [num_patterns * 7],
    output int                            received,
    output int                            value_errors,
    output int                            other_errors
);

    logic extra_seen;

    task automatic compare(
        input string       name,
        input int          line,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (expected !== actual) begin
            $display("** Error [%s] line %0d: expected %h, actual %h",
                name, line, expected, actual);
            value_errors++;
        end
    endtask

    always @(posedge clock) begin
        int          base;
        logic [31:0] flags;
        if (!rst_n) begin
            received     = 0;
            value_errors = 0;
            other_errors = 0;
            extra_seen   = 1'b0;
        end else if (out_valid && received >= num_patterns) begin
            // nothing may follow the halt word
            if (!extra_seen) begin
                $display("out_valid raised again after the final packet was dispatched");
                other_errors++;
                extra_seen = 1'b1;
            end
        end else if (out_valid && out_ready) begin
            base = received * 7;
            // pattern columns are word, fu_type, alu_func, opa, opb, flags and rs-used
            flags = {23'b0, out_packet.has_dest, out_packet.rd_mem, out_packet.wr_mem,
                     out_packet.cond_branch, out_packet.uncond_branch, out_packet.mult,
                     out_packet.csr_op, out_packet.halt, out_packet.illegal};
            compare("inst", received, patterns[base], out_packet.inst);
            compare("pc", received, 32'(received * 4), out_packet.pc);
            compare("npc", received, 32'(received * 4 + 4), out_packet.npc);
            // funct3 sits in bits 14 to 12 of every format
            compare("funct3", received, {29'b0, patterns[base][14:12]},
                {29'b0, out_packet.funct3});
            compare("fu_type", received, patterns[base + 1], {30'b0, out_packet.fu_type});
            compare("alu_func", received, patterns[base + 2], {28'b0, out_packet.alu_func});
            compare("opa_select", received, patterns[base + 3],
                {30'b0, out_packet.opa_select});
            compare("opb_select", received, patterns[base + 4],
                {29'b0, out_packet.opb_select});
            compare("flags", received, patterns[base + 5], flags);
            compare("rs_used", received, patterns[base + 6],
                {30'b0, out_packet.is_rs1_used, out_packet.is_rs2_used});
            // halted was set when the halt word entered the queue
            if (received == num_patterns - 1 && halted !== 1'b1) begin
                $display("halted is not high when the halt word is dispatched");
                other_errors++;
            end
            received++;
        end
    end

endmodule

// ==== rv_decode_config.svh ====
// ******************************
// decode front end configuration
// reset pc, queue depth, flags
// ******************************

`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// decode queue entries, power of two from 2 upward
`define RV_QUEUE_DEPTH 4

// one-bit decode flag values
`define TRUE  1'b1
`define FALSE 1'b0

`endif

// ==== rv_decode_pkg.sv ====
// ******************************
// rv_decode_pkg
// instruction formats, decode selects and the decode packet
// ******************************

package rv_decode_pkg;

    // register-register format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    // branch offset is scattered, bit 0 is implied
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // one fetched word, read in whichever format the opcode implies
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } inst_t;

    typedef enum logic [1:0] {
        opa_is_rs1  = 2'h0,
        opa_is_pc   = 2'h1,
        opa_is_zero = 2'h2
    } opa_select_t;

    typedef enum logic [2:0] {
        opb_is_rs2   = 3'h0,
        opb_is_i_imm = 3'h1,
        opb_is_s_imm = 3'h2,
        opb_is_b_imm = 3'h3,
        opb_is_u_imm = 3'h4,
        opb_is_j_imm = 3'h5
    } opb_select_t;

    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_slt  = 4'h2,
        alu_sltu = 4'h3,
        alu_and  = 4'h4,
        alu_or   = 4'h5,
        alu_xor  = 4'h6,
        alu_sll  = 4'h7,
        alu_srl  = 4'h8,
        alu_sra  = 4'h9
    } alu_func_t;

    typedef enum logic [1:0] {
        alu  = 2'h0,
        ldst = 2'h1,
        mult = 2'h2,
        bu   = 2'h3
    } fu_type_t;

    // register indices are taken from inst, not duplicated here
    typedef struct packed {
        inst_t       inst;
        logic [31:0] pc;
        logic [31:0] npc;
        opa_select_t opa_select;
        opb_select_t opb_select;
        alu_func_t   alu_func;
        fu_type_t    fu_type;
        logic [2:0]  funct3;
        logic        has_dest;
        logic        rd_mem;
        logic        wr_mem;
        logic        cond_branch;
        logic        uncond_branch;
        logic        mult;
        logic        csr_op;
        logic        halt;
        logic        illegal;
        logic        is_rs1_used;
        logic        is_rs2_used;
    } decode_packet_t;

endpackage

// ==== rv_decode_top.sv ====
// ******************************
// fetch and decode front end
// AXI4-Lite instruction reads to a queue of decoded packets
// ******************************

`timescale 1ns/1ps

module rv_decode_top (
    input  logic                          clock,
    input  logic                          rst_n,
    output logic                          arvalid,
    output logic [31:0]                   araddr,
    output logic [2:0]                    arprot,
    input  logic                          arready,
    input  logic                          rvalid,
    input  logic [31:0]                   rdata,
    input  logic [1:0]                    rresp,
    output logic                          rready,
    output logic                          out_valid,
    input  logic                          out_ready,
    output rv_decode_pkg::decode_packet_t out_packet,
    output logic                          halted
);

    fetch_decode_if fd_if ();

    rv_decode_pkg::decode_packet_t dec_packet;
    logic                          dec_halt;

    fetch_unit u_fetch_unit (
        .clock   (clock),
        .rst_n   (rst_n),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arprot  (arprot),
        .arready (arready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rready  (rready),
        .halt_in (dec_halt),
        .fd      (fd_if.fetch),
        .halted  (halted)
    );

    // decodes the held word in the same cycle it is offered
    decoder u_decoder (
        .fd     (fd_if.sink),
        .packet (dec_packet),
        .halt   (dec_halt)
    );

    decode_queue u_decode_queue (
        .clock      (clock),
        .rst_n      (rst_n),
        .fd         (fd_if.sink),
        .in_packet  (dec_packet),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_packet (out_packet)
    );

endmodule

// ==== tb_rv_decode.sv ====
// ******************************
// testbench for the decode front end
// memory model, patterns and dispatch back-pressure
// ******************************

`timescale 1ns/1ps

module tb_rv_decode;

    localparam int num_patterns     = 30;
    localparam int pattern_cols     = 7;
    localparam int pattern_words    = num_patterns * pattern_cols;
    localparam int dispatch_timeout = 5000;
    localparam int quiet_cycles     = 200;

    logic                          clock;
    logic                          rst_n;
    logic                          arvalid;
    logic [31:0]                   araddr;
    logic [2:0]                    arprot;
    logic                          arready;
    logic                          rvalid;
    logic [31:0]                   rdata;
    logic [1:0]                    rresp;
    logic                          rready;
    logic                          out_valid;
    logic                          out_ready;
    rv_decode_pkg::decode_packet_t out_packet;
    logic                          halted;

    logic [31:0] patterns [pattern_words];
    logic [31:0] lcg_state;
    logic [31:0] req_addr;
    logic        ar_done;
    logic        r_done;
    logic        mem_busy;
    int          mem_delay;
    int          stall_cycles;
    int          received;
    int          value_errors;
    int          other_errors;
    int          setup_errors;
    int          assert_failures;
    logic        timed_out;

    rv_decode_top u_rv_decode_top (
        .clock      (clock),
        .rst_n      (rst_n),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arprot     (arprot),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rready     (rready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_packet (out_packet),
        .halted     (halted)
    );

    rv_decode_checker #(.num_patterns(num_patterns)) u_rv_decode_checker (
        .clock        (clock),
        .rst_n        (rst_n),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_packet   (out_packet),
        .halted       (halted),
        .patterns     (patterns),
        .received     (received),
        .value_errors (value_errors),
        .other_errors (other_errors)
    );

    bind rv_decode_top rv_decode_assertions u_rv_decode_assertions (
        .clock      (clock),
        .rst_n      (rst_n),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arprot     (arprot),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_packet (out_packet),
        .halted     (halted)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // line i of the pattern file sits at address 4i and the rest reads as zero
    function automatic logic [31:0] memory_word(input logic [31:0] addr);
        int index;
        index = int'(addr[31:2]);
        if (index < num_patterns) begin
            return patterns[index * pattern_cols];
        end
        return 32'h0;
    endfunction

    // handshakes seen at the rising edge are acted on at the next falling edge
    always @(posedge clock) begin
        ar_done <= rst_n && arvalid && arready;
        r_done  <= rst_n && rvalid && rready;
        if (arvalid && arready) begin
            req_addr <= araddr;
        end
    end

    always @(negedge clock) begin
        logic [31:0] rnd;
        if (!rst_n) begin
            arready      = 1'b0;
            rvalid       = 1'b0;
            rdata        = 32'h0;
            out_ready    = 1'b0;
            mem_busy     = 1'b0;
            mem_delay    = 0;
            stall_cycles = 0;
        end else begin
            if (ar_done) begin
                mem_busy  = 1'b1;
                rnd       = lcg_next();
                mem_delay = int'(rnd[17:16]);
            end
            if (r_done) begin
                rvalid   = 1'b0;
                mem_busy = 1'b0;
            end
            // data comes back after 0 to 3 idle cycles
            if (mem_busy && !rvalid) begin
                if (mem_delay == 0) begin
                    rvalid = 1'b1;
                    rdata  = memory_word(req_addr);
                end else begin
                    mem_delay--;
                end
            end
            rnd     = lcg_next();
            arready = !mem_busy && rnd[18];
            // long dispatch stalls fill the queue and hold the fetch unit back
            if (stall_cycles > 0) begin
                stall_cycles--;
            end else if (rnd[25:22] == 4'h0) begin
                stall_cycles = 32 + 4 * int'(rnd[28:26]);
            end
            out_ready = (stall_cycles == 0) && (rnd[21:20] != 2'b00);
        end
    end

    initial begin
        int cycles;
        lcg_state    = 32'd1234;
        rst_n        = 1'b0;
        arready      = 1'b0;
        rvalid       = 1'b0;
        rdata        = 32'h0;
        rresp        = 2'b00;
        out_ready    = 1'b0;
        timed_out    = 1'b0;
        setup_errors = 0;
        $readmemh("decode_patterns.hex", patterns);
        if ($isunknown(patterns[pattern_words - 1])) begin
            $display("pattern file is missing or shorter than %0d lines", num_patterns);
            setup_errors++;
        end

        repeat (16) @(posedge clock);
        @(negedge clock);
        rst_n <= 1'b1;

        cycles = 0;
        while (received < num_patterns && cycles < dispatch_timeout) begin
            @(negedge clock);
            cycles++;
        end
        if (received < num_patterns) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d packets dispatched", received, num_patterns);
        end else begin
            // the checker flags any out_valid inside this window
            repeat (quiet_cycles) @(negedge clock);
        end

        assert_failures = u_rv_decode_top.u_rv_decode_assertions.failures;
        $display("summary: %0d of %0d packets, %0d value errors, %0d other errors, %0d %s",
            received, num_patterns, value_errors, other_errors + setup_errors,
            assert_failures, "assertion failures");
        if (timed_out || value_errors != 0 || other_errors != 0 || setup_errors != 0
            || assert_failures != 0) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule
